// File: mask_pkg.sv
`default_nettype none

package mask_pkg;

    // ==========================================================
    // Share representation
    // ==========================================================

    localparam int unsigned NUM_SHARES = 2;    // First-order masking

    // Two Boolean shares of one bit, share 1 in the upper position
    typedef logic [NUM_SHARES-1:0] bit_share_t;

    // Operand bundle of one masked full adder stage
    typedef struct packed {
        bit_share_t x;      // Re-masked share of x0 bit
        bit_share_t y;      // Re-masked share of x1 bit
        bit_share_t c_in;   // Carry from the previous stage
        logic       rnd;    // Fresh bit for the cross-domain refresh
    } fa_operand_t;

    // ==========================================================
    // Share helpers
    // ==========================================================

    // Split a plain bit into two shares with mask m
    function automatic bit_share_t split_bit(input logic v, input logic m);
        return {m, v ^ m};
    endfunction

    // Share-wise XOR of three shared bits, no domain crossing
    function automatic bit_share_t share_xor3(input bit_share_t a,
                                              input bit_share_t b,
                                              input bit_share_t c);
        return a ^ b ^ c;
    endfunction

endpackage

`default_nettype wire

// File: a2b_ctrl_pkg.sv
`default_nettype none

package a2b_ctrl_pkg;

    // ==========================================================
    // Randomness source
    // ==========================================================

    localparam int unsigned LFSR_POLY_W = 32;  // Internal LFSR state width

    // ==========================================================
    // Controller types
    // ==========================================================

    // Count sized for up to 64 items in flight
    localparam int unsigned IN_FLIGHT_W = 7;

    // Controller state
    typedef enum logic {
        IDLE = 1'b0,    // Nothing in the pipeline
        BUSY = 1'b1     // At least one item in flight
    } ctrl_state_e;

    // Status seen at the top level
    typedef struct packed {
        logic                   out_valid;  // s0/s1 hold a result this cycle
        logic                   busy;       // Pipeline not empty
        logic [IN_FLIGHT_W-1:0] in_flight;  // Items accepted, not yet out
    } a2b_status_t;

endpackage

`default_nettype wire

// File: masked_full_adder.sv
`timescale 1ns/1ns
`default_nettype none

module masked_full_adder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  zeroize,
    input  mask_pkg::fa_operand_t op,
    output mask_pkg::bit_share_t  s,
    output mask_pkg::bit_share_t  c_out
);

    // Majority rewritten as a single AND
    // maj(x, y, c) = ((x ^ c) & (y ^ c)) ^ c
    mask_pkg::bit_share_t a;        // x ^ c_in, per share
    mask_pkg::bit_share_t b;        // y ^ c_in, per share
    mask_pkg::bit_share_t inner_d;  // Same-domain products plus c_in share
    mask_pkg::bit_share_t cross_d;  // Cross-domain products, refreshed
    mask_pkg::bit_share_t sum_d;
    mask_pkg::bit_share_t inner_q;
    mask_pkg::bit_share_t cross_q;
    mask_pkg::bit_share_t sum_q;

    assign a = op.x ^ op.c_in;
    assign b = op.y ^ op.c_in;

    // ==========================================================
    // Domain-oriented masked AND
    // ==========================================================

    // Domain 0 keeps a0&b0 and a0&b1, domain 1 keeps a1&b1 and a1&b0
    assign inner_d[0] = (a[0] & b[0]) ^ op.c_in[0];
    assign inner_d[1] = (a[1] & b[1]) ^ op.c_in[1];
    assign cross_d[0] = (a[0] & b[1]) ^ op.rnd;    // Refresh before the register
    assign cross_d[1] = (a[1] & b[0]) ^ op.rnd;

    // Sum needs no randomness, plain share-wise XOR
    assign sum_d = mask_pkg::share_xor3(op.x, op.y, op.c_in);

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            inner_q <= '0;
            cross_q <= '0;
            sum_q   <= '0;
        end else begin
            inner_q <= inner_d;
            cross_q <= cross_d;
            sum_q   <= sum_d;
        end
    end

    assign s     = sum_q;
    // Compression after the register, each XOR stays within one domain
    assign c_out = inner_q ^ cross_q;

endmodule

`default_nettype wire

// File: masked_a2b_conv.sv
`timescale 1ns/1ns
`default_nettype none

module masked_a2b_conv #(
    parameter int unsigned WIDTH = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             zeroize,
    input  mask_pkg::bit_share_t [WIDTH-1:0] x,       // [i][0] from x0, [i][1] from x1
    input  logic [WIDTH-1:0]                 rnd,     // Carry refresh bits
    input  logic [WIDTH-1:0]                 rnd_b0,  // Masks for the x0 bits
    input  logic [WIDTH-1:0]                 rnd_b1,  // Masks for the x1 bits
    output mask_pkg::bit_share_t [WIDTH-1:0] s
);

    // Ripple chain, one element per bit position
    mask_pkg::bit_share_t carry   [WIDTH];
    mask_pkg::bit_share_t sum_bit [WIDTH];

    assign carry[0] = '0;  // No carry into bit 0

    // ==========================================================
    // Per-bit slice
    // ==========================================================

    for (genvar i = 0; i < WIDTH; i++) begin : gen_bit
        mask_pkg::bit_share_t [i:0]       xa_dly;   // x0 bit, re-masked, delayed i
        mask_pkg::bit_share_t [i:0]       xb_dly;   // x1 bit, re-masked, delayed i
        mask_pkg::bit_share_t [WIDTH-1:i] sum_dly;  // Output alignment

        // Re-mask each arithmetic share bit, then wait for the carry
        always_ff @(posedge clk) begin
            if (!rst_n || zeroize) begin
                xa_dly <= '0;
                xb_dly <= '0;
            end else begin
                xa_dly[0] <= mask_pkg::split_bit(x[i][0], rnd_b0[i]);
                xb_dly[0] <= mask_pkg::split_bit(x[i][1], rnd_b1[i]);
                for (int j = 1; j <= i; j++) begin
                    xa_dly[j] <= xa_dly[j-1];
                    xb_dly[j] <= xb_dly[j-1];
                end
            end
        end

        if (i < WIDTH-1) begin : gen_fa
            mask_pkg::fa_operand_t op;

            // Carry into bit i arrives i cycles after sampling
            assign op = '{x:    xa_dly[i],
                          y:    xb_dly[i],
                          c_in: carry[i],
                          rnd:  rnd[i]};

            masked_full_adder u_masked_full_adder (
                .clk     (clk),
                .rst_n   (rst_n),
                .zeroize (zeroize),
                .op      (op),
                .s       (sum_bit[i]),
                .c_out   (carry[i+1])
            );
        end else begin : gen_top
            mask_pkg::bit_share_t top_sum_q;

            // Top bit, carry out is discarded so only the XOR is needed
            always_ff @(posedge clk) begin
                if (!rst_n || zeroize) begin
                    top_sum_q <= '0;
                end else begin
                    top_sum_q <= mask_pkg::share_xor3(xa_dly[i], xb_dly[i], carry[i]);
                end
            end

            assign sum_bit[i] = top_sum_q;
        end

        // Low bits finish early, hold them until the top bit is done
        always_ff @(posedge clk) begin
            if (!rst_n || zeroize) begin
                sum_dly <= '0;
            end else begin
                sum_dly[i] <= sum_bit[i];
                for (int j = i + 1; j < WIDTH; j++) begin
                    sum_dly[j] <= sum_dly[j-1];
                end
            end
        end

        assign s[i] = sum_dly[WIDTH-1];  // All bits leave at WIDTH+2
    end

    // ==========================================================
    // Checks
    // ==========================================================

    // Every stage down to the output register drops its contents together
    a_zeroize_clears_out : assert property (
        @(posedge clk) disable iff (!rst_n)
        zeroize |=> (s == '0)
    ) else $error("masked_a2b_conv: s not cleared after zeroize");

endmodule

`default_nettype wire

// File: a2b_rnd_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

module a2b_rnd_lfsr #(
    parameter int unsigned                          WIDTH = 8,
    parameter logic [a2b_ctrl_pkg::LFSR_POLY_W-1:0] SEED  = 32'h1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             zeroize,
    output logic [WIDTH-1:0] rnd,
    output logic [WIDTH-1:0] rnd_b0,
    output logic [WIDTH-1:0] rnd_b1
);

    localparam int unsigned SW = a2b_ctrl_pkg::LFSR_POLY_W;

    // x^32 + x^22 + x^2 + x + 1, right-shifting Galois form
    localparam logic [SW-1:0] TAPS = 32'h8020_0003;

    // Rotation offsets, bit ranges stay apart for WIDTH up to SW/3
    localparam int unsigned ROT_B0 = SW / 3;
    localparam int unsigned ROT_B1 = 2 * SW / 3;

    logic [SW-1:0] state_q;
    logic [SW-1:0] state_d;
    logic [SW-1:0] rot_b0;
    logic [SW-1:0] rot_b1;

    if (WIDTH > SW / 3) begin : gen_width_check
        $error("a2b_rnd_lfsr: WIDTH too large for three disjoint random words");
    end

    // One step per cycle
    assign state_d = state_q[0] ? ((state_q >> 1) ^ TAPS) : (state_q >> 1);

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            state_q <= SEED;  // Wipe also restarts the sequence
        end else begin
            state_q <= state_d;
        end
    end

    assign rot_b0 = (state_q >> ROT_B0) | (state_q << (SW - ROT_B0));
    assign rot_b1 = (state_q >> ROT_B1) | (state_q << (SW - ROT_B1));

    assign rnd    = state_q[WIDTH-1:0];
    assign rnd_b0 = rot_b0[WIDTH-1:0];
    assign rnd_b1 = rot_b1[WIDTH-1:0];

    // Zero is the lock-up state of the register
    a_state_nonzero : assert property (
        @(posedge clk) disable iff (!rst_n)
        state_q != '0
    ) else $error("a2b_rnd_lfsr: LFSR state is zero");

endmodule

`default_nettype wire

// File: a2b_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module a2b_ctrl #(
    parameter int unsigned WIDTH = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      zeroize,
    input  logic                      in_valid,
    output a2b_ctrl_pkg::a2b_status_t status
);

    localparam int unsigned LATENCY = WIDTH + 2;  // Same as the converter
    localparam int unsigned CNT_W   = a2b_ctrl_pkg::IN_FLIGHT_W;

    logic [LATENCY-1:0]        vld_sr;   // One bit per pipeline stage
    logic                      out_valid;
    logic [CNT_W-1:0]          cnt_q;
    logic [CNT_W-1:0]          cnt_d;
    a2b_ctrl_pkg::ctrl_state_e state_q;
    a2b_ctrl_pkg::ctrl_state_e state_d;

    if (LATENCY > 64) begin : gen_depth_check
        $error("a2b_ctrl: pipeline deeper than the in_flight count");
    end

    // ==========================================================
    // Valid delay line
    // ==========================================================

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            vld_sr <= '0;  // Dropped items never report out_valid
        end else begin
            vld_sr <= {vld_sr[LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = vld_sr[LATENCY-1];

    // ==========================================================
    // In-flight count and state
    // ==========================================================

    assign cnt_d = cnt_q + CNT_W'(in_valid) - CNT_W'(out_valid);

    always_comb begin
        state_d = state_q;
        case (state_q)
            a2b_ctrl_pkg::IDLE: if (in_valid) state_d = a2b_ctrl_pkg::BUSY;
            a2b_ctrl_pkg::BUSY: if (cnt_d == '0) state_d = a2b_ctrl_pkg::IDLE;
            default:            state_d = a2b_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            cnt_q   <= '0;
            state_q <= a2b_ctrl_pkg::IDLE;
        end else begin
            cnt_q   <= cnt_d;
            state_q <= state_d;
        end
    end

    assign status = '{out_valid: out_valid,
                      busy:      (state_q == a2b_ctrl_pkg::BUSY),
                      in_flight: cnt_q};

    // Delay line and counter must agree on what is in flight
    a_valid_counted : assert property (
        @(posedge clk) disable iff (!rst_n)
        status.out_valid |-> (status.in_flight != '0)
    ) else $error("a2b_ctrl: out_valid with nothing in flight");

endmodule

`default_nettype wire

// File: masked_a2b_top.sv
`timescale 1ns/1ns
`default_nettype none

module masked_a2b_top #(
    parameter int unsigned                          WIDTH = 8,
    parameter logic [a2b_ctrl_pkg::LFSR_POLY_W-1:0] SEED  = 32'h1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      zeroize,
    input  logic                      in_valid,
    input  logic [WIDTH-1:0]          x0,      // Arithmetic share 0
    input  logic [WIDTH-1:0]          x1,      // Arithmetic share 1
    output logic [WIDTH-1:0]          s0,      // Boolean share 0
    output logic [WIDTH-1:0]          s1,      // Boolean share 1
    output a2b_ctrl_pkg::a2b_status_t status
);

    logic [WIDTH-1:0]                 rnd;
    logic [WIDTH-1:0]                 rnd_b0;
    logic [WIDTH-1:0]                 rnd_b1;
    mask_pkg::bit_share_t [WIDTH-1:0] x_sh;  // Per-bit share pairs in
    mask_pkg::bit_share_t [WIDTH-1:0] s_sh;  // Per-bit share pairs out

    // Word shares to per-bit pairs and back
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            x_sh[i] = {x1[i], x0[i]};
            s0[i]   = s_sh[i][0];
            s1[i]   = s_sh[i][1];
        end
    end

    // ==========================================================
    // Instances
    // ==========================================================

    a2b_rnd_lfsr #(
        .WIDTH (WIDTH),
        .SEED  (SEED)
    ) u_a2b_rnd_lfsr (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .rnd     (rnd),
        .rnd_b0  (rnd_b0),
        .rnd_b1  (rnd_b1)
    );

    masked_a2b_conv #(
        .WIDTH (WIDTH)
    ) u_masked_a2b_conv (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .x       (x_sh),
        .rnd     (rnd),
        .rnd_b0  (rnd_b0),
        .rnd_b1  (rnd_b1),
        .s       (s_sh)
    );

    // Tracks the strobe alongside the datapath
    a2b_ctrl #(
        .WIDTH (WIDTH)
    ) u_a2b_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .zeroize  (zeroize),
        .in_valid (in_valid),
        .status   (status)
    );

endmodule

`default_nettype wire

// File: tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Running totals for the closing summary
int check_count = 0;
int error_count = 0;

// Failure that is not a wrong value, e.g. a missing out_valid
task automatic report_failure(input string msg);
    error_count++;
    $display("failure at %0t: %s", $time, msg);
endtask

// Recombined value or a single share word
task automatic check_value(input string what, input logic [WIDTH-1:0] exp,
                           input logic [WIDTH-1:0] got);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, what, exp, got);
    end
endtask

// Whole status word, all three fields at once
task automatic check_status(input string what, input a2b_ctrl_pkg::a2b_status_t exp,
                            input a2b_ctrl_pkg::a2b_status_t got);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s expected vld %b busy %b cnt %0d, got %b %b %0d",
                 $time, what, exp.out_valid, exp.busy, exp.in_flight,
                 got.out_valid, got.busy, got.in_flight);
    end
endtask

// Cycles from strobe to out_valid
task automatic check_latency(input string what, input int exp, input int got);
    check_count++;
    if (got != exp) begin
        error_count++;
        $display("mismatch at %0t: %s latency expected %0d, got %0d", $time, what, exp, got);
    end
endtask

`endif

// File: tb_masked_a2b.sv
`timescale 1ns/1ns
`default_nettype none

module tb_masked_a2b;

    localparam int unsigned WIDTH   = 8;
    localparam int unsigned LATENCY = WIDTH + 2;  // Strobe edge to out_valid edge
    localparam int unsigned TIMEOUT = 4 * WIDTH;
    localparam int unsigned N_ITEMS = 20;         // Back-to-back stream length

    logic                      clk;
    logic                      rst_n;
    logic                      zeroize;
    logic                      in_valid;
    logic [WIDTH-1:0]          x0;
    logic [WIDTH-1:0]          x1;
    logic [WIDTH-1:0]          s0;
    logic [WIDTH-1:0]          s1;
    a2b_ctrl_pkg::a2b_status_t status;
    int                        seed = 92026;
    int                        test_count = 0;

    `include "tb_checks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    masked_a2b_top #(
        .WIDTH (WIDTH),
        .SEED  (32'h1)
    ) i_masked_a2b_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .zeroize  (zeroize),
        .in_valid (in_valid),
        .x0       (x0),
        .x1       (x1),
        .s0       (s0),
        .s1       (s1),
        .status   (status)
    );

    // ==========================================================
    // Helpers, outputs sampled on the falling edge
    // ==========================================================

    task automatic wait_out_valid(output int cycles, output bit found);
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            found = status.out_valid;
        end
    endtask

    // One strobe, returns the shares and the measured latency
    task automatic convert(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                           output logic [WIDTH-1:0] r0, output logic [WIDTH-1:0] r1,
                           output int lat, output bit ok);
        int cycles;
        @(posedge clk);
        in_valid <= 1'b1;
        x0       <= a;
        x1       <= b;
        @(posedge clk);
        in_valid <= 1'b0;  // Strobe sampled on this edge
        wait_out_valid(cycles, ok);
        lat = cycles + 1;
        r0  = s0;
        r1  = s1;
    endtask

    task automatic convert_and_check(input string name, input logic [WIDTH-1:0] a,
                                     input logic [WIDTH-1:0] b);
        logic [WIDTH-1:0] r0;
        logic [WIDTH-1:0] r1;
        int               lat;
        bit               ok;
        convert(a, b, r0, r1, lat, ok);
        if (!ok) begin
            report_failure({name, ": out_valid never came"});
        end else begin
            check_value({name, " sum"}, WIDTH'(a + b), r0 ^ r1);  // Sum wraps mod 2^WIDTH
            check_latency(name, LATENCY, lat);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        test_count++;
        $display("test %s finished, %0d errors", name, error_count - err_before);
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================

    task automatic run_status_test();
        int err0 = error_count;
        int cycles = 0;
        @(negedge clk);
        check_status("after reset", '{out_valid: 1'b0, busy: 1'b0, in_flight: 7'd0}, status);
        repeat (3) begin
            @(posedge clk);
            in_valid <= 1'b1;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_status("3 in flight", '{out_valid: 1'b0, busy: 1'b1, in_flight: 7'd3}, status);
        while (status.busy && cycles < TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        if (status.busy) report_failure("busy stayed high after the pipeline drained");
        check_status("drained", '{out_valid: 1'b0, busy: 1'b0, in_flight: 7'd0}, status);
        finish_test("status", err0);
    endtask

    task automatic run_edge_test();
        int err0 = error_count;
        logic [WIDTH-1:0] ea [6] = '{8'hff, 8'h80, 8'hff, 8'h01, 8'h00, 8'h7f};
        logic [WIDTH-1:0] eb [6] = '{8'h01, 8'h80, 8'hff, 8'hfe, 8'h00, 8'h81};
        for (int i = 0; i < 6; i++) begin
            convert_and_check("edge", ea[i], eb[i]);  // Full carry ripple, wrap, all ones
        end
        finish_test("edge", err0);
    endtask

    task automatic run_stream_test();
        int err0 = error_count;
        logic [WIDTH-1:0] sa [N_ITEMS];
        logic [WIDTH-1:0] sb [N_ITEMS];
        int               cycles;
        bit               found;
        for (int i = 0; i < N_ITEMS; i++) begin
            sa[i] = WIDTH'($random(seed));
            sb[i] = WIDTH'($random(seed));
        end
        fork
            begin
                for (int i = 0; i < N_ITEMS; i++) begin
                    @(posedge clk);
                    in_valid <= 1'b1;
                    x0       <= sa[i];
                    x1       <= sb[i];
                end
                @(posedge clk);
                in_valid <= 1'b0;
            end
            begin
                wait_out_valid(cycles, found);
                if (!found) report_failure("stream: first out_valid never came");
                for (int i = 0; found && i < N_ITEMS; i++) begin
                    if (i > 0) @(negedge clk);
                    if (!status.out_valid) report_failure("stream: gap in out_valid");
                    check_value("stream sum", WIDTH'(sa[i] + sb[i]), s0 ^ s1);
                end
                @(negedge clk);
                if (status.out_valid) report_failure("stream: extra out_valid after last");
            end
        join
        finish_test("stream", err0);
    endtask

    task automatic run_zeroize_test();
        int err0 = error_count;
        int cycles;
        bit found;
        repeat (4) begin
            @(posedge clk);
            in_valid <= 1'b1;
            x0       <= WIDTH'($random(seed));
            x1       <= WIDTH'($random(seed));
        end
        @(posedge clk);
        in_valid <= 1'b0;
        zeroize  <= 1'b1;
        x0       <= '0;
        x1       <= '0;
        @(posedge clk);
        zeroize  <= 1'b0;  // Wipe sampled on this edge
        @(negedge clk);
        check_value("zeroize s0", '0, s0);
        check_value("zeroize s1", '0, s1);
        check_status("zeroize", '{out_valid: 1'b0, busy: 1'b0, in_flight: 7'd0}, status);
        wait_out_valid(cycles, found);
        if (found) report_failure("zeroize: dropped item still raised out_valid");
        convert_and_check("after zeroize", WIDTH'($random(seed)), WIDTH'($random(seed)));
        finish_test("zeroize", err0);
    endtask

    task automatic run_masking_test();
        int err0 = error_count;
        logic [WIDTH-1:0] a = WIDTH'($random(seed));
        logic [WIDTH-1:0] b = WIDTH'($random(seed));
        logic [WIDTH-1:0] r0 [2];
        logic [WIDTH-1:0] r1 [2];
        int               lat;
        bit               ok;
        for (int k = 0; k < 2; k++) begin
            convert(a, b, r0[k], r1[k], lat, ok);
            if (!ok) report_failure("masking: out_valid never came");
            check_value("masking sum", WIDTH'(a + b), r0[k] ^ r1[k]);
        end
        if (r0[0] === r0[1] && r1[0] === r1[1]) begin
            report_failure("masking: shares identical on both runs");  // LFSR had moved on
        end
        finish_test("masking", err0);
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================

    initial begin
        int err0;
        rst_n    = 1'b0;
        zeroize  = 1'b0;
        in_valid = 1'b0;
        x0       = '0;
        x1       = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        run_status_test();
        err0 = error_count;
        convert_and_check("single", WIDTH'($random(seed)), WIDTH'($random(seed)));
        finish_test("single", err0);
        run_edge_test();
        run_stream_test();
        run_zeroize_test();
        run_masking_test();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
mask_pkg.sv
a2b_ctrl_pkg.sv
masked_full_adder.sv
masked_a2b_conv.sv
a2b_rnd_lfsr.sv
a2b_ctrl.sv
masked_a2b_top.sv
tb_masked_a2b.sv

// File: Bender.yml
package:
  name: masked_a2b

sources:
  - files:
      - mask_pkg.sv
      - a2b_ctrl_pkg.sv
      - masked_full_adder.sv
      - masked_a2b_conv.sv
      - a2b_rnd_lfsr.sv
      - a2b_ctrl.sv
      - masked_a2b_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_masked_a2b.sv
